// ==== Makefile ====
# Verilator build and run of the axis2udp testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = axis2udp_tb
FILELIST = axis2udp.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then pass only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== axis2udp.f ====
hw/udp_pkg.sv
hw/stream_fifo.sv
hw/packet_length_counter.sv
hw/udp_header_builder.sv
hw/udp_framer.sv
hw/axis2udp.sv
tests/tb_clock.sv
tests/axis2udp_asserts.sv
tests/axis2udp_tb.sv

// ==== hw/axis2udp.sv ====
// Top level; DATA_FIFO_DEPTH must hold the largest packet or the stream deadlocks, output padded to 64 bytes
`timescale 1ns/1ps

module axis2udp #(
   parameter int          DATA_FIFO_DEPTH = 64,
   parameter int          LEN_FIFO_DEPTH  = 32,
   parameter logic [7:0]  SRC_MAC_LOW     = 8'h02,
   parameter logic [31:0] SRC_IP          = 32'h0A01_0102,
   parameter logic [31:0] DST_IP          = 32'h0A01_01FF,
   parameter logic [15:0] SRC_PORT        = 16'd1000,
   parameter logic [15:0] DST_PORT        = 16'd32002
) (
   input  logic           clk,
   input  logic           resetn,
   input  udp_pkg::beat_t in_data,
   input  udp_pkg::keep_t in_keep,
   input  logic           in_valid,
   input  logic           in_last,
   output logic           in_ready,
   output udp_pkg::beat_t tx_data,
   output logic           tx_valid,
   output logic           tx_last,
   input  logic           tx_ready
);

   localparam int data_w = udp_pkg::beat_bytes * 8 + 1;

   // ==========================================================
   // Input side
   // ==========================================================
   logic          beat_ok;
   logic          data_wr_ready;
   logic          len_wr_ready;
   udp_pkg::len_t pkt_len;
   logic          pkt_len_valid;

   // Accept only when both FIFOs have room, so beat and length never split
   assign in_ready = data_wr_ready && len_wr_ready;
   assign beat_ok  = in_valid && in_ready;

   // Output side of the FIFOs toward the framer
   logic [data_w-1:0] rd_word;
   logic              rd_valid;
   logic              rd_ready;
   udp_pkg::len_t     len_head;
   logic              len_valid;
   logic              len_ready;

   stream_fifo #(.WIDTH(data_w), .DEPTH(DATA_FIFO_DEPTH)) data_fifo_i (
      .clk(clk), .resetn(resetn),
      .wr_data({in_last, in_data}), .wr_valid(beat_ok), .wr_ready(data_wr_ready),
      .rd_data(rd_word), .rd_valid(rd_valid), .rd_ready(rd_ready)
   );

   packet_length_counter counter_i (
      .clk(clk), .resetn(resetn), .keep(in_keep), .beat_ok(beat_ok),
      .last(in_last), .total(pkt_len), .total_valid(pkt_len_valid)
   );

   stream_fifo #(.WIDTH(16), .DEPTH(LEN_FIFO_DEPTH)) len_fifo_i (
      .clk(clk), .resetn(resetn),
      .wr_data(pkt_len), .wr_valid(pkt_len_valid), .wr_ready(len_wr_ready),
      .rd_data(len_head), .rd_valid(len_valid), .rd_ready(len_ready)
   );

   udp_framer #(
      .SRC_MAC_LOW(SRC_MAC_LOW), .SRC_IP(SRC_IP), .DST_IP(DST_IP),
      .SRC_PORT(SRC_PORT), .DST_PORT(DST_PORT)
   ) framer_i (
      .clk(clk), .resetn(resetn),
      .len_data(len_head), .len_valid(len_valid), .len_ready(len_ready),
      .rx_data(rd_word[data_w-2:0]), .rx_last(rd_word[data_w-1]),
      .rx_valid(rd_valid), .rx_ready(rd_ready),
      .tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last), .tx_ready(tx_ready)
   );

endmodule

// ==== hw/packet_length_counter.sv ====
// Sums tkeep bits per packet; expects a byte-packed stream where only the last beat may be partial
`timescale 1ns/1ps

module packet_length_counter (
   input  logic            clk,
   input  logic            resetn,
   input  udp_pkg::keep_t  keep,
   input  logic            beat_ok,
   input  logic            last,
   output udp_pkg::len_t   total,
   output logic            total_valid
);

   localparam int cnt_w = $clog2(udp_pkg::beat_bytes + 1);

   // Bytes carried by the current beat
   logic [cnt_w-1:0] beat_count;

   // Bytes of the packet accepted before the current beat
   udp_pkg::len_t run_sum;

   // ==========================================================
   // Population count of the keep bits
   // ==========================================================
   always_comb begin
      beat_count = '0;
      for (int i = 0; i < udp_pkg::beat_bytes; i++) begin
         beat_count = beat_count + cnt_w'(keep[i]);
      end
   end

   // The total includes the current beat, so it is ready on the last beat itself
   assign total       = run_sum + udp_pkg::len_t'(beat_count);
   assign total_valid = beat_ok && last;

   // Running sum restarts on every last beat
   always_ff @(posedge clk) begin
      if (!resetn) begin
         run_sum <= '0;
      end else if (beat_ok) begin
         if (last) begin
            run_sum <= '0;
         end else begin
            run_sum <= total;
         end
      end
   end

endmodule

// ==== hw/stream_fifo.sv ====
// Show-ahead synchronous FIFO; DEPTH must be 2 or more, and there is no simultaneous write when full
`timescale 1ns/1ps

module stream_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             wr_valid,
   output logic             wr_ready,
   output logic [WIDTH-1:0] rd_data,
   output logic             rd_valid,
   input  logic             rd_ready
);

   localparam int aw = $clog2(DEPTH);
   localparam int cw = $clog2(DEPTH + 1);

   // Storage array, read asynchronously at the head
   logic [WIDTH-1:0] mem [DEPTH];
   logic [aw-1:0]    wr_ptr;
   logic [aw-1:0]    rd_ptr;
   logic [cw-1:0]    count;
   logic             do_wr;
   logic             do_rd;

   assign wr_ready = (count != cw'(DEPTH));
   assign rd_valid = (count != '0);
   assign rd_data  = mem[rd_ptr];

   assign do_wr = wr_valid && wr_ready;
   assign do_rd = rd_valid && rd_ready;

   // The array itself is written only on an accepted write
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap at DEPTH-1 so any depth works, not just powers of two
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == aw'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == aw'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // A push and a pop in the same cycle leave the occupancy unchanged
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== hw/udp_framer.sv ====
// Header plus shifted payload; a length must only appear once its whole packet sits in the data FIFO
`timescale 1ns/1ps

module udp_framer #(
   parameter logic [7:0]  SRC_MAC_LOW = 8'h02,
   parameter logic [31:0] SRC_IP      = 32'h0A01_0102,
   parameter logic [31:0] DST_IP      = 32'h0A01_01FF,
   parameter logic [15:0] SRC_PORT    = 16'd1000,
   parameter logic [15:0] DST_PORT    = 16'd32002
) (
   input  logic           clk,
   input  logic           resetn,
   input  udp_pkg::len_t  len_data,
   input  logic           len_valid,
   output logic           len_ready,
   input  udp_pkg::beat_t rx_data,
   input  logic           rx_last,
   input  logic           rx_valid,
   output logic           rx_ready,
   output udp_pkg::beat_t tx_data,
   output logic           tx_valid,
   output logic           tx_last,
   input  logic           tx_ready
);

   localparam int hdr_w = udp_pkg::header_bytes * 8;
   localparam int rem_w = udp_pkg::rem_bytes * 8;

   udp_pkg::framer_state_t state_q;
   udp_pkg::header_t       header;

   // Upper 42 bytes of the last popped beat, still owed to the output
   logic [hdr_w-1:0] stored_q;
   logic             tx_fire;

   udp_header_builder #(
      .SRC_MAC_LOW (SRC_MAC_LOW),
      .SRC_IP      (SRC_IP),
      .DST_IP      (DST_IP),
      .SRC_PORT    (SRC_PORT),
      .DST_PORT    (DST_PORT)
   ) header_i (
      .payload_len (len_data),
      .header      (header)
   );

   // ==========================================================
   // Output beat selection
   // ==========================================================
   always_comb begin
      tx_valid = 1'b0;
      tx_data  = '0;
      unique case (state_q)
         udp_pkg::IDLE: begin
            // Header beat needs both the length and the first data beat
            tx_valid = len_valid && rx_valid;
            tx_data  = {rx_data[rem_w-1:0], header};
         end
         udp_pkg::BODY: begin
            tx_valid = rx_valid;
            tx_data  = {rx_data[rem_w-1:0], stored_q};
         end
         udp_pkg::TAIL: begin
            // Remaining payload with zero fill above it
            tx_valid = 1'b1;
            tx_data  = {{rem_w{1'b0}}, stored_q};
         end
         default: begin
            tx_valid = 1'b0;
            tx_data  = '0;
         end
      endcase
   end

   assign tx_last = (state_q == udp_pkg::TAIL);
   assign tx_fire = tx_valid && tx_ready;

   // Nothing is popped unless the output beat that uses it is accepted
   assign len_ready = (state_q == udp_pkg::IDLE) && tx_fire;
   assign rx_ready  = (state_q != udp_pkg::TAIL) && tx_fire;

   // Keep the unsent upper lanes of each consumed beat
   always_ff @(posedge clk) begin
      if (rx_ready && rx_valid) begin
         stored_q <= rx_data[rem_w +: hdr_w];
      end
   end

   // ==========================================================
   // State sequencing
   // ==========================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= udp_pkg::IDLE;
      end else if (tx_fire) begin
         unique case (state_q)
            udp_pkg::IDLE: state_q <= rx_last ? udp_pkg::TAIL : udp_pkg::BODY;
            udp_pkg::BODY: begin
               if (rx_last) begin
                  state_q <= udp_pkg::TAIL;
               end
            end
            udp_pkg::TAIL: state_q <= udp_pkg::IDLE;
            default:       state_q <= udp_pkg::IDLE;
         endcase
      end
   end

endmodule

// ==== hw/udp_header_builder.sv ====
// Combinational Eth/IPv4/UDP header; no IP options, UDP checksum left at zero, carry folded once
`timescale 1ns/1ps

module udp_header_builder #(
   parameter logic [7:0]  SRC_MAC_LOW = 8'h02,
   parameter logic [31:0] SRC_IP      = 32'h0A01_0102,
   parameter logic [31:0] DST_IP      = 32'h0A01_01FF,
   parameter logic [15:0] SRC_PORT    = 16'd1000,
   parameter logic [15:0] DST_PORT    = 16'd32002
) (
   input  udp_pkg::len_t    payload_len,
   output udp_pkg::header_t header
);

   // UDP checksum is optional over IPv4 and is sent as zero
   localparam logic [15:0] udp_csum = 16'h0000;

   logic [15:0]      ip_total_len;
   logic [15:0]      udp_len;
   logic [31:0]      csum_sum;
   logic [15:0]      csum_fold;
   logic [15:0]      ip_csum;
   udp_pkg::header_t hdr_be;

   assign ip_total_len = payload_len + udp_pkg::ip_hdr_overhead;
   assign udp_len      = payload_len + udp_pkg::udp_hdr_overhead;

   // ==========================================================
   // IPv4 header checksum over the nine non-checksum words
   // ==========================================================
   assign csum_sum = 32'(udp_pkg::ip_ver_dsf) + 32'(ip_total_len)
                   + 32'(udp_pkg::ip_ident) + 32'(udp_pkg::ip_flags)
                   + 32'(udp_pkg::ip_ttl_proto)
                   + 32'(SRC_IP[31:16]) + 32'(SRC_IP[15:0])
                   + 32'(DST_IP[31:16]) + 32'(DST_IP[15:0]);

   // Nine 16-bit words cannot carry far, one fold is enough for these field values
   assign csum_fold = csum_sum[15:0] + csum_sum[31:16];
   assign ip_csum   = ~csum_fold;

   // Header as it reads on the wire, first byte in the top bits
   assign hdr_be = {
      udp_pkg::dst_mac,
      udp_pkg::mac_prefix, SRC_MAC_LOW,
      udp_pkg::eth_type,
      udp_pkg::ip_ver_dsf, ip_total_len,
      udp_pkg::ip_ident, udp_pkg::ip_flags,
      udp_pkg::ip_ttl_proto, ip_csum,
      SRC_IP, DST_IP,
      SRC_PORT, DST_PORT,
      udp_len, udp_csum
   };

   // The stream sends lane 0 first, so the byte order is reversed here
   for (genvar i = 0; i < udp_pkg::header_bytes; i++) begin : g_swap
      assign header[i*8 +: 8] = hdr_be[(udp_pkg::header_bytes - 1 - i)*8 +: 8];
   end

endmodule

// ==== hw/udp_pkg.sv ====
// Shared sizes, header field values and framer states; assumes a fixed 64-byte beat and IPv4/UDP only
package udp_pkg;

   // ==========================================================
   // Beat and header geometry
   // ==========================================================

   // Byte lanes in one stream beat
   localparam int beat_bytes = 64;

   // Ethernet (14) + IPv4 (20) + UDP (8) header bytes
   localparam int header_bytes = 42;

   // Payload lanes left over in the beat that carries the header
   localparam int rem_bytes = beat_bytes - header_bytes;

   typedef logic [beat_bytes*8-1:0]   beat_t;
   typedef logic [beat_bytes-1:0]     keep_t;
   typedef logic [15:0]               len_t;
   typedef logic [header_bytes*8-1:0] header_t;

   // ==========================================================
   // Fixed protocol field values
   // ==========================================================
   localparam logic [15:0] eth_type     = 16'h0800;
   localparam logic [15:0] ip_ver_dsf   = 16'h4500;
   localparam logic [15:0] ip_ident     = 16'hDEAD;
   // Don't-fragment flag set, fragment offset zero
   localparam logic [15:0] ip_flags     = 16'h4000;
   // TTL of 64 with protocol 17 (UDP)
   localparam logic [15:0] ip_ttl_proto = 16'h4011;
   localparam logic [39:0] mac_prefix   = 40'hC4_00_AD_00_00;
   // Frames always go to the broadcast address
   localparam logic [47:0] dst_mac      = 48'hFFFF_FFFF_FFFF;

   // Bytes that the IPv4 total length and UDP length add on top of the payload
   localparam logic [15:0] ip_hdr_overhead  = 16'd28;
   localparam logic [15:0] udp_hdr_overhead = 16'd8;

   // Framer phases: header beat, body beats, final tail beat
   typedef enum logic [1:0] {IDLE, BODY, TAIL} framer_state_t;

endpackage

// ==== tests/axis2udp_asserts.sv ====
// Output stream protocol checks bound into axis2udp; stability checks are idle while resetn is low
`timescale 1ns/1ps

module axis2udp_asserts (
   input logic           clk,
   input logic           resetn,
   input logic           in_ready,
   input udp_pkg::beat_t tx_data,
   input logic           tx_valid,
   input logic           tx_last,
   input logic           tx_ready
);

   // Number of assertion failures seen so far
   int assert_errors = 0;

   // A stalled beat must stay offered and unchanged until it is taken
   property hold_while_stalled;
      @(posedge clk) disable iff (!resetn)
         (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last));
   endproperty

   property last_needs_valid;
      @(posedge clk) disable iff (!resetn)
         tx_last |-> tx_valid;
   endproperty

   // Both FIFOs are empty straight out of reset
   property ready_after_reset;
      @(posedge clk) $rose(resetn) |-> in_ready;
   endproperty

   stall_hold_a: assert property (hold_while_stalled)
      else begin
         $error("tx_data or tx_last changed while the output beat was stalled");
         assert_errors++;
      end

   last_valid_a: assert property (last_needs_valid)
      else begin
         $error("tx_last was high without tx_valid");
         assert_errors++;
      end

   reset_ready_a: assert property (ready_after_reset)
      else begin
         $error("in_ready was low in the first cycle after reset");
         assert_errors++;
      end

endmodule

// ==== tests/axis2udp_tb.sv ====
// Table-driven packets with random payload; assumes 64-byte beats and a data FIFO deep enough for 4 beats
`timescale 1ns/1ps

module axis2udp_tb;

   // Address fields given to the DUT and used by the reference header
   localparam logic [7:0]  src_mac_low = 8'h5A;
   localparam logic [31:0] src_ip      = 32'hC0A8_0A01;
   localparam logic [31:0] dst_ip      = 32'hC0A8_0AFF;
   localparam logic [15:0] src_port    = 16'd4000;
   localparam logic [15:0] dst_port    = 16'd5000;

   // ==========================================================
   // Stimulus table: beats, kept bytes on the last beat, random tx_ready
   // ==========================================================
   localparam int n_rows = 8;
   localparam int row_beats [n_rows] = '{1, 3, 2, 1, 4, 2, 1, 3};
   localparam int row_keep  [n_rows] = '{64, 10, 64, 1, 33, 22, 42, 43};
   localparam bit row_rand  [n_rows] = '{0, 0, 0, 0, 0, 1, 1, 1};

   logic           clk;
   logic           resetn;
   udp_pkg::beat_t in_data;
   udp_pkg::keep_t in_keep;
   logic           in_valid;
   logic           in_last;
   logic           in_ready;
   udp_pkg::beat_t tx_data;
   logic           tx_valid;
   logic           tx_last;
   // Sink is always ready until a random row takes over
   logic           tx_ready = 1'b1;
   bit             rand_ready = 1'b0;

   // Separate generator states for payload bytes and for tx_ready
   logic [31:0] data_state  = 32'h292b;
   logic [31:0] ready_state = 32'h292b;

   // Reference model queues, one entry per expected output beat or frame
   udp_pkg::beat_t exp_beats [$];
   logic           exp_lasts [$];
   logic           exp_firsts [$];
   udp_pkg::len_t  exp_ip_lens [$];
   udp_pkg::len_t  exp_udp_lens [$];
   udp_pkg::beat_t exp_beat;
   logic           exp_last;
   logic           exp_first;

   int err_beat  = 0;
   int err_len   = 0;
   int err_last  = 0;
   int err_other = 0;

   tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(8)) clock_i (.clk(clk), .resetn(resetn));

   axis2udp #(
      .DATA_FIFO_DEPTH(16), .LEN_FIFO_DEPTH(8), .SRC_MAC_LOW(src_mac_low),
      .SRC_IP(src_ip), .DST_IP(dst_ip), .SRC_PORT(src_port), .DST_PORT(dst_port)
   ) dut_i (
      .clk(clk), .resetn(resetn),
      .in_data(in_data), .in_keep(in_keep), .in_valid(in_valid), .in_last(in_last),
      .in_ready(in_ready),
      .tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last), .tx_ready(tx_ready)
   );

   bind axis2udp axis2udp_asserts asserts_i (.*);

   // ==========================================================
   // Random numbers and the reference header
   // ==========================================================
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [7:0] next_byte();
      data_state = xorshift32(data_state);
      return data_state[7:0];
   endfunction

   // Header in wire order with byte 0 in lane 0, checksum folded until no carry is left
   function automatic udp_pkg::header_t expected_header(input udp_pkg::len_t plen);
      logic [7:0]       w [42];
      logic [15:0]      ip_len;
      logic [15:0]      udp_len;
      logic [15:0]      csum;
      logic [31:0]      sum;
      udp_pkg::header_t h;
      ip_len  = plen + 16'd28;
      udp_len = plen + 16'd8;
      sum = 32'h4500 + 32'(ip_len) + 32'hDEAD + 32'h4000 + 32'h4011
          + 32'(src_ip[31:16]) + 32'(src_ip[15:0]) + 32'(dst_ip[31:16]) + 32'(dst_ip[15:0]);
      while (sum[31:16] != 16'h0) begin
         sum = 32'(sum[15:0]) + 32'(sum[31:16]);
      end
      csum = ~sum[15:0];
      w = '{8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF,
            8'hC4, 8'h00, 8'hAD, 8'h00, 8'h00, src_mac_low,
            8'h08, 8'h00, 8'h45, 8'h00, ip_len[15:8], ip_len[7:0],
            8'hDE, 8'hAD, 8'h40, 8'h00, 8'h40, 8'h11, csum[15:8], csum[7:0],
            src_ip[31:24], src_ip[23:16], src_ip[15:8], src_ip[7:0],
            dst_ip[31:24], dst_ip[23:16], dst_ip[15:8], dst_ip[7:0],
            src_port[15:8], src_port[7:0], dst_port[15:8], dst_port[7:0],
            udp_len[15:8], udp_len[7:0], 8'h00, 8'h00};
      for (int k = 0; k < 42; k++) begin
         h[k*8 +: 8] = w[k];
      end
      return h;
   endfunction

   // ==========================================================
   // Compare tasks
   // ==========================================================
   task automatic check_beat(input string name, input udp_pkg::beat_t got,
                             input udp_pkg::beat_t exp);
      if (got !== exp) begin
         err_beat++;
         $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_len(input string name, input udp_pkg::len_t got,
                            input udp_pkg::len_t exp);
      if (got !== exp) begin
         err_len++;
         $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_last(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         err_last++;
         $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // ==========================================================
   // Packet driver and model
   // ==========================================================
   task automatic send_packet(input int beats, input int last_keep, input bit rnd);
      udp_pkg::beat_t pkt [$];
      logic [7:0]     stream [$];
      udp_pkg::beat_t b;
      udp_pkg::header_t h;
      udp_pkg::keep_t mask;
      udp_pkg::len_t  plen;
      plen = udp_pkg::len_t'(64 * (beats - 1) + last_keep);
      rand_ready <= rnd;
      // Unkept lanes get random bytes too, since they pass through unchanged
      for (int i = 0; i < beats; i++) begin
         for (int k = 0; k < 64; k++) begin
            b[k*8 +: 8] = next_byte();
         end
         pkt.push_back(b);
      end
      h = expected_header(plen);
      for (int k = 0; k < 42; k++) begin
         stream.push_back(h[k*8 +: 8]);
      end
      foreach (pkt[i]) begin
         for (int k = 0; k < 64; k++) begin
            stream.push_back(pkt[i][k*8 +: 8]);
         end
      end
      // Zero fill completes the tail beat
      for (int k = 0; k < 22; k++) begin
         stream.push_back(8'h00);
      end
      for (int o = 0; o <= beats; o++) begin
         for (int k = 0; k < 64; k++) begin
            b[k*8 +: 8] = stream[o*64 + k];
         end
         exp_beats.push_back(b);
         exp_lasts.push_back(o == beats);
         exp_firsts.push_back(o == 0);
      end
      exp_ip_lens.push_back(plen + 16'd28);
      exp_udp_lens.push_back(plen + 16'd8);
      mask = '0;
      for (int k = 0; k < last_keep; k++) begin
         mask[k] = 1'b1;
      end
      for (int i = 0; i < beats; i++) begin
         @(negedge clk);
         in_data  = pkt[i];
         in_keep  = (i == beats - 1) ? mask : '1;
         in_last  = (i == beats - 1);
         in_valid = 1'b1;
         // in_ready depends only on FIFO fill, so it is settled between edges
         while (in_ready !== 1'b1) @(negedge clk);
         @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
      in_last  = 1'b0;
      in_keep  = '0;
   endtask

   // Random back-pressure, driven on the falling edge like every other input
   always @(negedge clk) begin
      if (rand_ready) begin
         ready_state = xorshift32(ready_state);
         tx_ready = ready_state[16];
      end else begin
         tx_ready = 1'b1;
      end
   end

   // Output monitor, sampling the beat that the rising edge accepts
   always @(posedge clk) begin
      if (resetn && tx_valid && tx_ready) begin
         if (exp_beats.size() == 0) begin
            err_other++;
            $display("Output beat at %0t arrived with no frame outstanding", $time);
         end else begin
            exp_beat  = exp_beats.pop_front();
            exp_last  = exp_lasts.pop_front();
            exp_first = exp_firsts.pop_front();
            check_beat("tx_data", tx_data, exp_beat);
            check_last("tx_last", tx_last, exp_last);
            if (exp_first) begin
               check_len("ip_total_len", {tx_data[16*8 +: 8], tx_data[17*8 +: 8]},
                         exp_ip_lens.pop_front());
               check_len("udp_len", {tx_data[38*8 +: 8], tx_data[39*8 +: 8]},
                         exp_udp_lens.pop_front());
            end
         end
      end
   end

   // Watchdog sized from the table, 200 cycles per input beat plus 50
   initial begin
      int limit;
      limit = 50;
      for (int r = 0; r < n_rows; r++) begin
         limit += 200 * row_beats[r];
      end
      repeat (limit) @(posedge clk);
      $display("Timeout after %0d cycles with %0d output beats still owed", limit,
               exp_beats.size());
      $display("TB FAILED");
      $finish;
   end

   // ==========================================================
   // Main sequence
   // ==========================================================
   initial begin
      int total;
      in_data  = '0;
      in_keep  = '0;
      in_valid = 1'b0;
      in_last  = 1'b0;
      @(posedge resetn);
      @(posedge clk);
      check_last("tx_valid", tx_valid, 1'b0);
      check_last("tx_last", tx_last, 1'b0);
      check_last("in_ready", in_ready, 1'b1);
      for (int r = 0; r < n_rows; r++) begin
         send_packet(row_beats[r], row_keep[r], row_rand[r]);
      end
      while (exp_beats.size() != 0) @(posedge clk);
      // Quiet period catches any extra output beat
      repeat (20) @(posedge clk);
      check_last("tx_valid", tx_valid, 1'b0);
      total = err_beat + err_len + err_last + err_other + dut_i.asserts_i.assert_errors;
      $display("Error counts: beat %0d, length %0d, last %0d, other %0d, assertion %0d",
               err_beat, err_len, err_last, err_other, dut_i.asserts_i.assert_errors);
      if (total == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== tests/tb_clock.sv ====
// Free-running clock and active-low reset; reset lifts on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic resetn
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release between edges so the first active edge sees a settled reset
   initial begin
      resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
   end

endmodule
